/* run.sh */
#!/bin/sh
# builds the decode-stage testbench with Verilator, runs it, checks sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module idStageTb \
    -f src.f -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "build or simulation step failed, see build.log and sim.log"
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim/idStageTb.sv */
/*
 * testbench for the decode stage with two cycles per table step
 * first cycle loads the IF/ID latch, second drives wb and load fields and checks
 * expected bus values come from a local register model
 * stops at the first error
 */

`timescale 1ns/10ps

module idStageTb;

    typedef struct packed {
        logic [31:0]     instr;
        logic [31:0]     pc;
        logic [2:0]      mode;      // {fetchAddrErr, idWr, idFlush}
        cpuPkg::wbWriteT wb;
        logic [11:0]     loads;     // {exeMemRead, exeRt, memMemRead, memRt}
        cpuPkg::ctrlT    ctrl;
        logic [31:0]     imm32;
        cpuPkg::exceptT  except;
        logic            stall;
    } stepT;

    localparam cpuPkg::wbWriteT noWb = '0;
    localparam cpuPkg::ctrlT noCtrl = '0;
    localparam logic [11:0] noLoad = 12'h000;
    localparam int fillLen = 31;

    logic            clk;
    logic            arstN;
    logic            idWr;
    logic            idFlush;
    cpuPkg::ifIdT    ifBus;
    cpuPkg::wbWriteT wb;
    logic [4:0]      exeRt;
    logic            exeMemRead;
    logic [4:0]      memRt;
    logic            memMemRead;
    cpuPkg::idExeT   idBus;
    logic            isImmJump;
    logic            dhStall;

    stepT          steps[$];
    logic [31:0]   model [0:31];
    logic [31:0]   lcgState;
    cpuPkg::instrT latchInstr;
    logic [31:0]   latchPc;
    int            curStep = -1;
    int            cycles = 0;
    int            cycleLimit = 1000;

    idStage uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopRun(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            stopRun($sformatf("timeout: no end of the stimulus table within %0d cycles",
                              cycleLimit));
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // register read as seen by decode, including the write-back bypass
    function automatic logic [31:0] modelRead(logic [4:0] addr, cpuPkg::wbWriteT w);
        if (addr == 5'd0) begin
            return 32'h0000_0000;
        end
        if (w.regWrite && (w.dst == addr)) begin
            return w.data;
        end
        return model[addr];
    endfunction

    task automatic checkWord(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stopRun($sformatf("MISMATCH at %0t: step %0d %s got %h expected %h",
                              $time, curStep, what, got, exp));
        end
    endtask

    task automatic checkBit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stopRun($sformatf("MISMATCH at %0t: step %0d %s got %b expected %b",
                              $time, curStep, what, got, exp));
        end
    endtask

    task automatic checkBus(input cpuPkg::idExeT got, input cpuPkg::idExeT exp);
        checkWord("idBus.pc", got.pc, exp.pc);
        checkWord("idBus.instr", got.instr, exp.instr);
        checkWord("idBus.busA", got.busA, exp.busA);
        checkWord("idBus.busB", got.busB, exp.busB);
        checkWord("idBus.imm32", got.imm32, exp.imm32);
        checkWord("idBus.ctrl", 32'(got.ctrl), 32'(exp.ctrl));
        checkWord("idBus.except", 32'(got.except), 32'(exp.except));
        checkWord("idBus.rs/rt/rd", {17'd0, got.rs, got.rt, got.rd},
                  {17'd0, exp.rs, exp.rt, exp.rd});
    endtask

    // instruction encoders
    function automatic logic [31:0] rIns(logic [5:0] fn, int rs, int rt, int rd);
        return {cpuPkg::opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] iIns(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] jIns(logic [5:0] op, logic [25:0] target);
        return {op, target};
    endfunction

    function automatic cpuPkg::ctrlT mkCtrl(cpuPkg::aluOpT op, logic [1:0] srcRw,
                                            cpuPkg::dstSelT dst, logic [1:0] mem,
                                            cpuPkg::branchT br, logic jmp);
        cpuPkg::ctrlT c;
        c.aluOp     = op;
        c.aluSrcImm = srcRw[1];
        c.regWrite  = srcRw[0];
        c.dstSel    = dst;
        c.memRead   = mem[1];
        c.memWrite  = mem[0];
        c.branch    = br;
        c.isImmJump = jmp;
        return c;
    endfunction

    function automatic cpuPkg::ctrlT rCtrl(cpuPkg::aluOpT op);
        return mkCtrl(op, 2'b01, cpuPkg::dstRd, 2'b00, cpuPkg::brNone, 1'b0);
    endfunction

    function automatic cpuPkg::ctrlT iCtrl(cpuPkg::aluOpT op);
        return mkCtrl(op, 2'b11, cpuPkg::dstRt, 2'b00, cpuPkg::brNone, 1'b0);
    endfunction

    function automatic logic [11:0] exeLoad(int r);
        return {1'b1, 5'(r), 6'd0};
    endfunction

    function automatic logic [11:0] memLoad(int r);
        return {6'd0, 1'b1, 5'(r)};
    endfunction

    function automatic cpuPkg::wbWriteT wbOf(int dst, logic [31:0] data);
        return {1'b1, 5'(dst), data};
    endfunction

    task automatic addStep(input logic [31:0] instr, input logic [31:0] pc,
                           input logic [2:0] mode, input cpuPkg::wbWriteT w,
                           input logic [11:0] loads, input cpuPkg::ctrlT c,
                           input logic [31:0] imm, input cpuPkg::exceptT ex,
                           input logic stall);
        stepT s;
        s.instr  = instr;
        s.pc     = pc;
        s.mode   = mode;
        s.wb     = w;
        s.loads  = loads;
        s.ctrl   = c;
        s.imm32  = imm;
        s.except = ex;
        s.stall  = stall;
        steps.push_back(s);
    endtask

    task automatic buildTable();
        // R-type reads and load-use cases
        addStep(rIns(cpuPkg::fnAddu, 1, 2, 3), 32'h0040_0000, 3'b010, noWb, exeLoad(1),
                rCtrl(cpuPkg::aluAdd), 32'h0000_1821, 2'b00, 1'b1);
        addStep(rIns(cpuPkg::fnSubu, 5, 6, 4), 32'h0040_0004, 3'b010, noWb, memLoad(6),
                rCtrl(cpuPkg::aluSub), 32'h0000_2023, 2'b00, 1'b1);
        addStep(rIns(cpuPkg::fnAnd, 8, 9, 7), 32'h0040_0008, 3'b010, noWb,
                {1'b0, 5'd8, 6'd0}, rCtrl(cpuPkg::aluAnd), 32'h0000_3824, 2'b00, 1'b0);
        addStep(rIns(cpuPkg::fnOr, 31, 0, 10), 32'h0040_000c, 3'b010, noWb, exeLoad(0),
                rCtrl(cpuPkg::aluOr), 32'h0000_5025, 2'b00, 1'b0);
        addStep(rIns(cpuPkg::fnSlt, 0, 30, 20), 32'h0040_0010, 3'b010, noWb, noLoad,
                rCtrl(cpuPkg::aluSlt), 32'hffff_a02a, 2'b00, 1'b0);
        // immediate forms and an ADDIU whose rt is not a source
        addStep(iIns(cpuPkg::opAddiu, 12, 11, 16'h8004), 32'h0040_0014, 3'b010, noWb,
                exeLoad(11), iCtrl(cpuPkg::aluAdd), 32'hffff_8004, 2'b00, 1'b0);
        addStep(iIns(cpuPkg::opLw, 1, 1, 16'h0000), 32'h0040_0018, 3'b000, noWb,
                memLoad(12), iCtrl(cpuPkg::aluAdd), 32'hffff_8004, 2'b00, 1'b1);
        addStep(iIns(cpuPkg::opAndi, 14, 13, 16'h8004), 32'h0040_001c, 3'b010, noWb,
                noLoad, iCtrl(cpuPkg::aluAnd), 32'h0000_8004, 2'b00, 1'b0);
        addStep(iIns(cpuPkg::opOri, 16, 15, 16'h1234), 32'h0040_0020, 3'b110, noWb,
                noLoad, iCtrl(cpuPkg::aluOr), 32'h0000_1234, 2'b10, 1'b0);
        addStep(iIns(cpuPkg::opLui, 0, 17, 16'habcd), 32'h0040_0024, 3'b010, noWb,
                exeLoad(17), mkCtrl(cpuPkg::aluLui, 2'b11, cpuPkg::dstRt, 2'b00,
                cpuPkg::brNone, 1'b0), 32'habcd_0000, 2'b00, 1'b0);
        addStep(iIns(cpuPkg::opLw, 19, 18, 16'h0010), 32'h0040_0028, 3'b010, noWb, noLoad,
                mkCtrl(cpuPkg::aluAdd, 2'b11, cpuPkg::dstRt, 2'b10, cpuPkg::brNone, 1'b0),
                32'h0000_0010, 2'b00, 1'b0);
        // hold with a write-back to the held source
        addStep(32'hffff_ffff, 32'h0040_002c, 3'b000, wbOf(19, 32'h0bad_f00d), noLoad,
                mkCtrl(cpuPkg::aluAdd, 2'b11, cpuPkg::dstRt, 2'b10, cpuPkg::brNone, 1'b0),
                32'h0000_0010, 2'b00, 1'b0);
        addStep(iIns(cpuPkg::opSw, 22, 21, 16'hfffc), 32'h0040_002c, 3'b010, noWb,
                memLoad(21), mkCtrl(cpuPkg::aluAdd, 2'b10, cpuPkg::dstRd, 2'b01,
                cpuPkg::brNone, 1'b0), 32'hffff_fffc, 2'b00, 1'b1);
        addStep(iIns(cpuPkg::opBeq, 1, 2, 16'hffff), 32'h0040_0030, 3'b010, noWb,
                memLoad(2), mkCtrl(cpuPkg::aluSub, 2'b00, cpuPkg::dstRd, 2'b00,
                cpuPkg::brEq, 1'b0), 32'hffff_ffff, 2'b00, 1'b1);
        addStep(iIns(cpuPkg::opBne, 3, 4, 16'h0003), 32'h0040_0034, 3'b010, noWb,
                noLoad, mkCtrl(cpuPkg::aluSub, 2'b00, cpuPkg::dstRd, 2'b00,
                cpuPkg::brNe, 1'b0), 32'h0000_0003, 2'b00, 1'b0);
        // jump targets keep pc[31:28]
        addStep(jIns(cpuPkg::opJ, 26'h012_3456), 32'h9000_0010, 3'b010, noWb, noLoad,
                mkCtrl(cpuPkg::aluAdd, 2'b00, cpuPkg::dstRd, 2'b00, cpuPkg::brNone, 1'b1),
                32'h9048_d158, 2'b00, 1'b0);
        addStep(jIns(cpuPkg::opJal, 26'h3ff_ffff), 32'h0040_0040, 3'b010, noWb,
                exeLoad(31), mkCtrl(cpuPkg::aluAdd, 2'b01, cpuPkg::dstRa, 2'b00,
                cpuPkg::brNone, 1'b1), 32'h0fff_fffc, 2'b00, 1'b0);
        // bypass on rs, on $0 and on rt
        addStep(rIns(cpuPkg::fnAddu, 6, 7, 5), 32'h0040_0044, 3'b010,
                wbOf(6, 32'hdead_beef), noLoad, rCtrl(cpuPkg::aluAdd), 32'h0000_2821,
                2'b00, 1'b0);
        addStep(rIns(cpuPkg::fnAnd, 0, 9, 2), 32'h0040_0048, 3'b010,
                wbOf(0, 32'h1111_1111), noLoad, rCtrl(cpuPkg::aluAnd), 32'h0000_1024,
                2'b00, 1'b0);
        addStep(rIns(cpuPkg::fnSubu, 9, 10, 8), 32'h0040_004c, 3'b010,
                wbOf(10, 32'h5a5a_0f0f), exeLoad(10), rCtrl(cpuPkg::aluSub),
                32'h0000_4023, 2'b00, 1'b1);
        // reserved opcode and funct
        addStep(32'hfc00_0000, 32'h0040_0050, 3'b010, noWb, noLoad, noCtrl,
                32'h0000_0000, 2'b01, 1'b0);
        addStep(rIns(6'h3f, 1, 2, 0), 32'h0040_0054, 3'b010, noWb, exeLoad(1), noCtrl,
                32'h0000_003f, 2'b01, 1'b0);
        // flush wins over idWr, then hold keeps the bubble
        addStep(rIns(cpuPkg::fnAddu, 1, 2, 3), 32'h0040_0058, 3'b011, noWb, noLoad,
                noCtrl, 32'h0000_0000, 2'b00, 1'b0);
        addStep(rIns(cpuPkg::fnOr, 4, 5, 6), 32'h0040_005c, 3'b000, noWb, noLoad,
                noCtrl, 32'h0000_0000, 2'b00, 1'b0);
        addStep(rIns(cpuPkg::fnOr, 31, 30, 29), 32'h0040_0060, 3'b010, noWb, noLoad,
                rCtrl(cpuPkg::aluOr), 32'hffff_e825, 2'b00, 1'b0);
    endtask

    initial begin
        stepT          st;
        cpuPkg::idExeT exp;

        arstN      = 1'b0;
        idWr       = 1'b0;
        idFlush    = 1'b0;
        ifBus      = '0;
        wb         = '0;
        exeRt      = 5'd0;
        exeMemRead = 1'b0;
        memRt      = 5'd0;
        memMemRead = 1'b0;
        lcgState   = 32'he29d_73a1;
        latchInstr = '0;
        latchPc    = 32'h0000_0000;
        for (int r = 0; r < 32; r++) begin
            model[r] = 32'h0000_0000;
        end
        buildTable();
        cycleLimit = 2 * steps.size() + fillLen + 50;

        repeat (5) @(posedge clk);
        #1 arstN = 1'b1;

        // bubble after reset
        #5;
        exp = '0;
        checkBus(idBus, exp);
        checkBit("dhStall", dhStall, 1'b0);
        checkBit("isImmJump", isImmJump, 1'b0);
        @(posedge clk);
        #1;

        // random contents for $1..$31 through the write-back port
        for (int r = 1; r <= fillLen; r++) begin
            wb.regWrite = 1'b1;
            wb.dst      = 5'(r);
            wb.data     = nextRand();
            model[r]    = wb.data;
            @(posedge clk);
            #1;
        end
        wb = '0;

        foreach (steps[k]) begin
            st      = steps[k];
            curStep = k;
            ifBus.instr  = st.instr;
            ifBus.pc     = st.pc;
            ifBus.except = {st.mode[2], 1'b0};
            idWr         = st.mode[1];
            idFlush      = st.mode[0];
            wb           = '0;
            {exeMemRead, exeRt, memMemRead, memRt} = noLoad;
            @(posedge clk);
            #1;
            if (st.mode[0]) begin
                latchInstr = '0;
                latchPc    = 32'h0000_0000;
            end else if (st.mode[1]) begin
                latchInstr = st.instr;
                latchPc    = st.pc;
            end

            // decode cycle
            idWr    = 1'b0;
            idFlush = 1'b0;
            wb      = st.wb;
            {exeMemRead, exeRt, memMemRead, memRt} = st.loads;
            #5;
            exp        = '0;
            exp.pc     = latchPc;
            exp.instr  = latchInstr;
            exp.rs     = latchInstr.r.rs;
            exp.rt     = latchInstr.r.rt;
            exp.rd     = latchInstr.r.rd;
            exp.busA   = modelRead(latchInstr.r.rs, st.wb);
            exp.busB   = modelRead(latchInstr.r.rt, st.wb);
            exp.imm32  = st.imm32;
            exp.ctrl   = st.ctrl;
            exp.except = st.except;
            checkBus(idBus, exp);
            checkBit("isImmJump", isImmJump, st.ctrl.isImmJump);
            checkBit("dhStall", dhStall, st.stall);
            if (st.wb.regWrite && (st.wb.dst != 5'd0)) begin
                model[st.wb.dst] = st.wb.data;
            end
            @(posedge clk);
            #1;
        end

        if (uut.uChk.failCount == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stopRun("checker assertions failed during the run");
        end
    end

endmodule

/* sim/idStage_chk.sv */
/*
 * concurrent checks on the decode stage, bound into every idStage
 * checks are off while arstN is low
 */

`timescale 1ns/10ps

module idStageChk (
    input logic          clk,
    input logic          arstN,
    input logic          idFlush,
    input cpuPkg::idExeT idBus,
    input logic          dhStall
);
    int unsigned failCount = 0;

    stallKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(dhStall))
        else begin
            $error("dhStall is unknown out of reset");
            failCount++;
        end

    // flushed slot carries no side effects
    flushBubble: assert property (@(posedge clk) disable iff (!arstN)
        idFlush |=> !(idBus.ctrl.regWrite || idBus.ctrl.memRead || idBus.ctrl.memWrite))
        else begin
            $error("controls active in the cycle after a flush");
            failCount++;
        end

    zeroReg: assert property (@(posedge clk) disable iff (!arstN)
        (idBus.rs == 5'd0) |-> (idBus.busA == 32'h0000_0000))
        else begin
            $error("busA not zero for source register 0");
            failCount++;
        end

endmodule

bind idStage idStageChk uChk (.*);

/* src.f */
src/cpuPkg.sv
src/idReg.sv
src/regFile.sv
src/decoder.sv
src/hazardUnit.sv
src/idStage.sv
sim/idStage_chk.sv
sim/idStageTb.sv

/* src/cpuPkg.sv */
/*
 * shared types of the instruction-decode stage
 * fixed 32-bit MIPS-style ISA, 32 registers, no configurable widths
 * opcodes outside the listed subset are decoded as reserved
 */

package cpuPkg;

    // one instruction word read three ways
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iTypeT;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target26;
    } jTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
        jTypeT j;
    } instrT;

    typedef struct packed {
        logic fetchAddrErr;
        logic reservedInstr;
    } exceptT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOpT;

    typedef enum logic [1:0] {
        dstRd,
        dstRt,
        dstRa
    } dstSelT;

    typedef enum logic [1:0] {
        brNone,
        brEq,
        brNe
    } branchT;

    typedef enum logic [1:0] {
        extZero,
        extSign,
        extHigh
    } extOpT;

    // fetch to decode
    typedef struct packed {
        instrT       instr;
        logic [31:0] pc;
        exceptT      except;
    } ifIdT;

    typedef struct packed {
        aluOpT  aluOp;
        logic   aluSrcImm;
        logic   regWrite;
        dstSelT dstSel;
        logic   memRead;
        logic   memWrite;
        branchT branch;
        logic   isImmJump;
    } ctrlT;

    typedef struct packed {
        logic        regWrite;
        logic [4:0]  dst;
        logic [31:0] data;
    } wbWriteT;

    // decode to execute
    typedef struct packed {
        logic [31:0] pc;
        instrT       instr;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] busA;
        logic [31:0] busB;
        logic [31:0] imm32;
        ctrlT        ctrl;
        exceptT      except;
    } idExeT;

    // bubble word with the encoding of sll $0,$0,0
    localparam logic [31:0] nopWord = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct codes under opSpecial
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

endpackage

/* src/decoder.sv */
/*
 * instruction decoder for ADDU SUBU AND OR SLT ADDIU ANDI ORI LUI LW SW
 * BEQ BNE J JAL, anything else raises reservedInstr with controls cleared
 * the all-zero bubble word decodes as a plain no-op without exception
 * rsRtRead is {rs read, rt read}
 */

`timescale 1ns/10ps

module decoder (
    input  cpuPkg::ifIdT    idLatch,
    output cpuPkg::ctrlT    ctrl,
    output logic [31:0]     imm32,
    output cpuPkg::exceptT  except,
    output logic [1:0]      rsRtRead
);
    cpuPkg::instrT instr;
    cpuPkg::ctrlT  rawCtrl;
    cpuPkg::extOpT extOp;
    logic [1:0]    rawRead;
    logic          reserved;
    logic          isBubble;

    assign instr    = idLatch.instr;
    assign isBubble = (instr == cpuPkg::nopWord);

    always_comb begin
        rawCtrl  = '0;
        rawRead  = 2'b00;
        extOp    = cpuPkg::extSign;
        reserved = 1'b0;
        case (instr.r.op)
            cpuPkg::opSpecial: begin
                rawCtrl.regWrite = 1'b1;
                rawCtrl.dstSel   = cpuPkg::dstRd;
                rawRead          = 2'b11;
                case (instr.r.funct)
                    cpuPkg::fnAddu: rawCtrl.aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSubu: rawCtrl.aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd:  rawCtrl.aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr:   rawCtrl.aluOp = cpuPkg::aluOr;
                    cpuPkg::fnSlt:  rawCtrl.aluOp = cpuPkg::aluSlt;
                    default:        reserved = !isBubble;
                endcase
            end
            cpuPkg::opAddiu, cpuPkg::opAndi, cpuPkg::opOri: begin
                rawCtrl.aluSrcImm = 1'b1;
                rawCtrl.regWrite  = 1'b1;
                rawCtrl.dstSel    = cpuPkg::dstRt;
                rawRead           = 2'b10;
                if (instr.i.op == cpuPkg::opAddiu) begin
                    rawCtrl.aluOp = cpuPkg::aluAdd;
                end else begin
                    extOp = cpuPkg::extZero;
                    rawCtrl.aluOp = (instr.i.op == cpuPkg::opAndi) ?
                                    cpuPkg::aluAnd : cpuPkg::aluOr;
                end
            end
            cpuPkg::opLui: begin
                rawCtrl.aluOp     = cpuPkg::aluLui;
                rawCtrl.aluSrcImm = 1'b1;
                rawCtrl.regWrite  = 1'b1;
                rawCtrl.dstSel    = cpuPkg::dstRt;
                extOp             = cpuPkg::extHigh;
            end
            cpuPkg::opLw: begin
                rawCtrl.aluSrcImm = 1'b1;
                rawCtrl.regWrite  = 1'b1;
                rawCtrl.dstSel    = cpuPkg::dstRt;
                rawCtrl.memRead   = 1'b1;
                rawRead           = 2'b10;
            end
            cpuPkg::opSw: begin
                // rt carries the store data
                rawCtrl.aluSrcImm = 1'b1;
                rawCtrl.memWrite  = 1'b1;
                rawRead           = 2'b11;
            end
            cpuPkg::opBeq, cpuPkg::opBne: begin
                rawCtrl.aluOp  = cpuPkg::aluSub;
                rawCtrl.branch = (instr.i.op == cpuPkg::opBeq) ?
                                 cpuPkg::brEq : cpuPkg::brNe;
                rawRead        = 2'b11;
            end
            cpuPkg::opJ: begin
                rawCtrl.isImmJump = 1'b1;
            end
            cpuPkg::opJal: begin
                // link address goes to $ra
                rawCtrl.isImmJump = 1'b1;
                rawCtrl.regWrite  = 1'b1;
                rawCtrl.dstSel    = cpuPkg::dstRa;
            end
            default: begin
                reserved = 1'b1;
            end
        endcase
    end

    // reserved and bubble words carry no controls and read nothing
    assign ctrl     = (reserved || isBubble) ? '0 : rawCtrl;
    assign rsRtRead = (reserved || isBubble) ? 2'b00 : rawRead;

    always_comb begin
        case (extOp)
            cpuPkg::extZero: imm32 = {16'h0000, instr.i.imm16};
            cpuPkg::extHigh: imm32 = {instr.i.imm16, 16'h0000};
            default:         imm32 = {{16{instr.i.imm16[15]}}, instr.i.imm16};
        endcase
        // jump target within the current 256 MB region
        if (ctrl.isImmJump) begin
            imm32 = {idLatch.pc[31:28], instr.j.target26, 2'b00};
        end
    end

    assign except.fetchAddrErr  = idLatch.except.fetchAddrErr;
    assign except.reservedInstr = idLatch.except.reservedInstr | reserved;

endmodule

/* src/hazardUnit.sv */
/*
 * load-use hazard detection
 * only write-back is bypassed, so loads in both EXE and MEM stall decode
 * register 0 never causes a stall
 */

`timescale 1ns/10ps

module hazardUnit (
    input  logic [4:0] rs,
    input  logic [4:0] rt,
    input  logic [1:0] rsRtRead,
    input  logic [4:0] exeRt,
    input  logic       exeMemRead,
    input  logic [4:0] memRt,
    input  logic       memMemRead,
    output logic       dhStall
);
    logic rsLive;
    logic rtLive;
    logic rsHit;
    logic rtHit;

    // sources actually read and not $0
    assign rsLive = rsRtRead[1] && (rs != 5'd0);
    assign rtLive = rsRtRead[0] && (rt != 5'd0);

    assign rsHit = rsLive && ((exeMemRead && (rs == exeRt)) ||
                              (memMemRead && (rs == memRt)));
    assign rtHit = rtLive && ((exeMemRead && (rt == exeRt)) ||
                              (memMemRead && (rt == memRt)));

    assign dhStall = rsHit || rtHit;

endmodule

/* src/idReg.sv */
/*
 * IF/ID pipeline register
 * flush wins over write enable and loads a bubble
 * reset also leaves a bubble in the latch
 */

`timescale 1ns/10ps

module idReg (
    input  logic          clk,
    input  logic          arstN,
    input  logic          idWr,
    input  logic          idFlush,
    input  cpuPkg::ifIdT  ifBus,
    output cpuPkg::ifIdT  idLatch
);
    // nop word, zero pc, no flags
    localparam cpuPkg::ifIdT bubble = '{
        instr:  cpuPkg::nopWord,
        pc:     32'h0000_0000,
        except: 2'b00
    };

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idLatch <= bubble;
        end else if (idFlush) begin
            idLatch <= bubble;
        end else if (idWr) begin
            idLatch <= ifBus;
        end
        // idWr low holds the stage
    end

endmodule

/* src/idStage.sv */
/*
 * instruction-decode stage top level
 * idWr is not gated by dhStall here, which the pipeline control does outside
 * idBus is combinational from the IF/ID latch and the write-back port
 */

`timescale 1ns/10ps

module idStage (
    input  logic             clk,
    input  logic             arstN,
    input  logic             idWr,
    input  logic             idFlush,
    input  cpuPkg::ifIdT     ifBus,
    input  cpuPkg::wbWriteT  wb,
    input  logic [4:0]       exeRt,
    input  logic             exeMemRead,
    input  logic [4:0]       memRt,
    input  logic             memMemRead,
    output cpuPkg::idExeT    idBus,
    output logic             isImmJump,
    output logic             dhStall
);
    cpuPkg::ifIdT   idLatch;
    cpuPkg::ctrlT   ctrl;
    cpuPkg::exceptT except;
    logic [31:0]    busA;
    logic [31:0]    busB;
    logic [31:0]    imm32;
    logic [1:0]     rsRtRead;

    idReg uIdReg (
        .clk     (clk),
        .arstN   (arstN),
        .idWr    (idWr),
        .idFlush (idFlush),
        .ifBus   (ifBus),
        .idLatch (idLatch)
    );

    regFile uRegFile (
        .clk   (clk),
        .arstN (arstN),
        .wb    (wb),
        .rs    (idLatch.instr.r.rs),
        .rt    (idLatch.instr.r.rt),
        .busA  (busA),
        .busB  (busB)
    );

    decoder uDecoder (
        .idLatch  (idLatch),
        .ctrl     (ctrl),
        .imm32    (imm32),
        .except   (except),
        .rsRtRead (rsRtRead)
    );

    hazardUnit uHazardUnit (
        .rs         (idLatch.instr.r.rs),
        .rt         (idLatch.instr.r.rt),
        .rsRtRead   (rsRtRead),
        .exeRt      (exeRt),
        .exeMemRead (exeMemRead),
        .memRt      (memRt),
        .memMemRead (memMemRead),
        .dhStall    (dhStall)
    );

    // outgoing bus to EXE
    assign idBus.pc     = idLatch.pc;
    assign idBus.instr  = idLatch.instr;
    assign idBus.rs     = idLatch.instr.r.rs;
    assign idBus.rt     = idLatch.instr.r.rt;
    assign idBus.rd     = idLatch.instr.r.rd;
    assign idBus.busA   = busA;
    assign idBus.busB   = busB;
    assign idBus.imm32  = imm32;
    assign idBus.ctrl   = ctrl;
    assign idBus.except = except;

    // early copy for PC selection in fetch
    assign isImmJump = idBus.ctrl.isImmJump;

endmodule

/* src/regFile.sv */
/*
 * 32 x 32 register file, register 0 hard-wired to zero
 * write takes effect at the clock edge
 * both read ports see a same-cycle write-back through a bypass
 */

`timescale 1ns/10ps

module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  cpuPkg::wbWriteT  wb,
    input  logic [4:0]       rs,
    input  logic [4:0]       rt,
    output logic [31:0]      busA,
    output logic [31:0]      busB
);
    logic [31:0] regs [1:31];
    logic        wbValid;

    // writes to register 0 are dropped
    assign wbValid = wb.regWrite && (wb.dst != 5'd0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (wbValid) begin
            regs[wb.dst] <= wb.data;
        end
    end

    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'h0000_0000;
        end else if (wbValid && (wb.dst == addr)) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    // reads follow the file contents and the write-back port as well as the address
    always_comb begin
        busA = readPort(rs);
        busB = readPort(rt);
    end

endmodule
